/* source/gpif_pkg.sv */
//////////////////////////////////////////////////
// gpif bus master shared definitions
// word and beat types, burst limits, fifo depth
// and the bus state and request encodings
//////////////////////////////////////////////////

package gpif_pkg;

   // one 16-bit line on the chip data bus
   typedef logic [15:0] gpif_word_t;

   // fifo entry, word plus start mark (bit 16) and end mark (bit 17)
   typedef logic [17:0] gpif_beat_t;

   // lines moved in the current burst
   typedef logic [9:0] xfer_count_t;

   // free entries in a fifo, wide enough to hold the full depth
   typedef logic [5:0] fifo_space_t;

   // burst limit for data, also the space data tx needs before it starts
   localparam int GPIF_DATA_XFER_LINES = 16;
   // control tx packet length
   localparam int GPIF_CTRL_XFER_LINES = 16;
   // non-rx cycles before a pending flush is forced
   localparam int GPIF_FLUSH_IDLE_CYCLES = 64;
   // every fifo in the design
   localparam int GPIF_FIFO_DEPTH = 32;

   // bus master states
   // the sloe and adr states give the chip one set-up cycle
   typedef enum logic [3:0] {
      IDLE,
      DATA_TX_SLOE,
      DATA_TX,
      CTRL_TX_SLOE,
      CTRL_TX,
      DATA_RX_ADR,
      DATA_RX,
      CTRL_RX_ADR,
      CTRL_RX,
      PKTEND_ADR,
      PKTEND
   } gpif_state_e;

   // winning request out of the flag decode
   typedef enum logic [2:0] {
      REQ_NONE,
      REQ_CTRL_TX,
      REQ_CTRL_RX,
      REQ_DATA_TX,
      REQ_DATA_RX,
      REQ_FLUSH
   } gpif_req_e;

endpackage

/* source/gpif_bus_if.sv */
//////////////////////////////////////////////////
// gpif internal bus
// flags and request from decode, state, count
// and beat strobes from execute
//////////////////////////////////////////////////

interface gpif_bus_if
   import gpif_pkg::*;
();

   // registered chip flags, active high here
   logic ep2_empty;
   logic ep4_empty;
   logic ep6_full;
   logic ep8_full;

   gpif_req_e   req;
   gpif_state_e state;
   xfer_count_t xfer_count;

   // a word comes from the chip this cycle
   logic rd_beat;
   // a word goes to the chip this cycle
   logic wr_beat;
   // a control endpoint (ep4 or ep8) is selected
   logic wr_ep_ctrl;

   modport decode (
      output ep2_empty, ep4_empty, ep6_full, ep8_full, req,
      input  state, wr_beat
   );

   modport execute (
      input  ep2_empty, ep4_empty, ep6_full, ep8_full, req,
      output state, xfer_count, rd_beat, wr_beat, wr_ep_ctrl
   );

   modport result (
      input state, xfer_count, rd_beat, wr_beat, wr_ep_ctrl
   );

endinterface

/* source/gpif_sync_fifo.sv */
//////////////////////////////////////////////////
// gpif sync fifo
// single clock circular buffer, a word moves when
// src_rdy and dst_rdy are both high
//////////////////////////////////////////////////

module gpif_sync_fifo
   import gpif_pkg::*;
(
   input  logic        gpif_clk,
   input  logic        gpif_rst,
   // write side
   input  gpif_beat_t  data_i,
   input  logic        src_rdy_i,
   output logic        dst_rdy_o,
   // read side
   output gpif_beat_t  data_o,
   output logic        src_rdy_o,
   input  logic        dst_rdy_i,
   output fifo_space_t space_o
);

   gpif_beat_t                         mem [GPIF_FIFO_DEPTH];
   logic [$clog2(GPIF_FIFO_DEPTH)-1:0] wr_ptr;
   logic [$clog2(GPIF_FIFO_DEPTH)-1:0] rd_ptr;
   fifo_space_t                        level;
   logic                               push;
   logic                               pop;

   // handshakes on both sides
   assign dst_rdy_o = (level != fifo_space_t'(GPIF_FIFO_DEPTH));
   assign src_rdy_o = (level != '0);
   assign push      = src_rdy_i & dst_rdy_o;
   assign pop       = src_rdy_o & dst_rdy_i;

   // head entry is always presented
   assign data_o  = mem[rd_ptr];
   assign space_o = fifo_space_t'(GPIF_FIFO_DEPTH) - level;

   // storage
   always_ff @(posedge gpif_clk)
   begin
      if (push)
         mem[wr_ptr] <= data_i;
   end

   // pointers wrap on their own since the depth is a power of two
   always_ff @(posedge gpif_clk)
   begin
      if (gpif_rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         // level only moves when exactly one side fires
         if (push && !pop)
            level <= level + 1'b1;
         else if (pop && !push)
            level <= level - 1'b1;
      end
   end

endmodule

/* source/gpif_flag_decode.sv */
//////////////////////////////////////////////////
// gpif flag decode
// registers the chip flags, tracks rx idle time,
// the pending flush and data bus fairness, then
// picks one request for the bus state machine
//////////////////////////////////////////////////

module gpif_flag_decode
   import gpif_pkg::*;
(
   input  logic        gpif_clk,
   input  logic        gpif_rst,
   // active low chip flags
   input  logic [3:0]  gpif_ctl_i,
   input  logic        dsp_rx_run_i,
   input  fifo_space_t data_tx_space_i,
   input  logic        ctrl_tx_dst_rdy_i,
   input  logic        data_rx_src_rdy_i,
   input  logic        ctrl_rx_src_rdy_i,
   // end mark of the data rx head word
   input  logic        data_rx_eof_i,
   gpif_bus_if.decode  bus
);

   // cycles since the last data rx burst, saturating
   logic [$clog2(GPIF_FLUSH_IDLE_CYCLES):0] non_rx_cycles;
   // last data user, 1 for tx and 0 for rx
   logic last_hog_tx;
   // a packet end went out on ep6 and has not been flushed yet
   logic pktend_latch;
   logic data_tx_ok;
   logic data_rx_ok;
   logic rx_flush;

   ////////////////////////////////////////////////
   // flag registers
   ////////////////////////////////////////////////

   // flags come up as empty and full so nothing starts out of reset
   always_ff @(posedge gpif_clk)
   begin
      if (gpif_rst)
      begin
         bus.ep2_empty <= 1'b1;
         bus.ep4_empty <= 1'b1;
         bus.ep6_full  <= 1'b1;
         bus.ep8_full  <= 1'b1;
      end
      else
      begin
         // flag a, ep2 empty
         bus.ep2_empty <= ~gpif_ctl_i[0];
         // flag b, ep4 empty
         bus.ep4_empty <= ~gpif_ctl_i[1];
         // flag c, ep6 full
         bus.ep6_full  <= ~gpif_ctl_i[2];
         // flag d, ep8 full
         bus.ep8_full  <= ~gpif_ctl_i[3];
      end
   end

   ////////////////////////////////////////////////
   // fairness, idle count and flush latch
   ////////////////////////////////////////////////

   // control traffic is short, only data tx against data rx counts
   always_ff @(posedge gpif_clk)
   begin
      if (gpif_rst)
         last_hog_tx <= 1'b0;
      else if (bus.state == DATA_TX)
         last_hog_tx <= 1'b1;
      else if (bus.state == DATA_RX)
         last_hog_tx <= 1'b0;
   end

   always_ff @(posedge gpif_clk)
   begin
      if (gpif_rst || bus.state == DATA_RX || bus.state == PKTEND)
         non_rx_cycles <= '0;
      else if (non_rx_cycles != GPIF_FLUSH_IDLE_CYCLES)
         non_rx_cycles <= non_rx_cycles + 1'b1;
   end

   // armed by the last word of an rx packet
   always_ff @(posedge gpif_clk)
   begin
      if (gpif_rst)
         pktend_latch <= 1'b0;
      else if (bus.state == PKTEND)
         pktend_latch <= 1'b0;
      else if (bus.state == DATA_RX && bus.wr_beat && data_rx_eof_i)
         pktend_latch <= 1'b1;
   end

   ////////////////////////////////////////////////
   // request selection
   ////////////////////////////////////////////////

   always_comb
   begin
      // data tx waits for room for a whole burst
      data_tx_ok = !bus.ep2_empty
                   && (data_tx_space_i >= fifo_space_t'(GPIF_DATA_XFER_LINES));
      data_rx_ok = data_rx_src_rdy_i && !bus.ep6_full;
      // flush when the dsp stopped or rx went quiet for long enough
      rx_flush   = pktend_latch && !bus.ep6_full
                   && (!dsp_rx_run_i || non_rx_cycles == GPIF_FLUSH_IDLE_CYCLES);

      bus.req = REQ_NONE;
      if (ctrl_tx_dst_rdy_i && !bus.ep4_empty)
         bus.req = REQ_CTRL_TX;
      else if (ctrl_rx_src_rdy_i && !bus.ep8_full)
         bus.req = REQ_CTRL_RX;
      // the data direction that waited goes first
      else if (data_tx_ok && !last_hog_tx)
         bus.req = REQ_DATA_TX;
      else if (data_rx_ok && last_hog_tx)
         bus.req = REQ_DATA_RX;
      else if (data_tx_ok)
         bus.req = REQ_DATA_TX;
      else if (data_rx_ok)
         bus.req = REQ_DATA_RX;
      else if (rx_flush)
         bus.req = REQ_FLUSH;
   end

endmodule

/* source/gpif_xfer_execute.sv */
//////////////////////////////////////////////////
// gpif transfer execute
// bus master state machine, burst line counter
// and the per-cycle read and write beats
//////////////////////////////////////////////////

module gpif_xfer_execute
   import gpif_pkg::*;
(
   input  logic        gpif_clk,
   input  logic        gpif_rst,
   // tx fifos have room
   input  logic        data_tx_dst_rdy_i,
   input  logic        ctrl_tx_dst_rdy_i,
   // rx fifos have a word
   input  logic        data_rx_src_rdy_i,
   input  logic        ctrl_rx_src_rdy_i,
   gpif_bus_if.execute bus
);

   logic data_tx_beat;
   logic ctrl_tx_beat;
   logic data_rx_beat;
   logic ctrl_rx_beat;
   logic xfer_beat;

   ////////////////////////////////////////////////
   // beat enables
   ////////////////////////////////////////////////

   // a beat needs the right state, the chip flag and the fifo side ready
   always_comb
   begin
      data_tx_beat = (bus.state == DATA_TX) && !bus.ep2_empty && data_tx_dst_rdy_i
                     && (bus.xfer_count != xfer_count_t'(GPIF_DATA_XFER_LINES));
      // control tx stops at one packet so the framing stays aligned
      ctrl_tx_beat = (bus.state == CTRL_TX) && !bus.ep4_empty && ctrl_tx_dst_rdy_i
                     && (bus.xfer_count != xfer_count_t'(GPIF_CTRL_XFER_LINES));
      data_rx_beat = (bus.state == DATA_RX) && !bus.ep6_full && data_rx_src_rdy_i
                     && (bus.xfer_count != xfer_count_t'(GPIF_DATA_XFER_LINES));
      ctrl_rx_beat = (bus.state == CTRL_RX) && !bus.ep8_full && ctrl_rx_src_rdy_i;
   end

   assign bus.rd_beat = data_tx_beat | ctrl_tx_beat;
   assign bus.wr_beat = data_rx_beat | ctrl_rx_beat;
   assign xfer_beat   = data_tx_beat | ctrl_tx_beat | data_rx_beat | ctrl_rx_beat;

   // ep4 and ep8 both sit at odd addresses
   assign bus.wr_ep_ctrl = (bus.state == CTRL_TX_SLOE) || (bus.state == CTRL_TX)
                           || (bus.state == CTRL_RX_ADR) || (bus.state == CTRL_RX);

   ////////////////////////////////////////////////
   // state machine
   ////////////////////////////////////////////////

   always_ff @(posedge gpif_clk)
   begin
      if (gpif_rst)
      begin
         bus.state      <= IDLE;
         bus.xfer_count <= '0;
      end
      else
      begin
         case (bus.state)
            IDLE:
            begin
               bus.xfer_count <= '0;
               case (bus.req)
                  REQ_CTRL_TX: bus.state <= CTRL_TX_SLOE;
                  REQ_CTRL_RX: bus.state <= CTRL_RX_ADR;
                  REQ_DATA_TX: bus.state <= DATA_TX_SLOE;
                  REQ_DATA_RX: bus.state <= DATA_RX_ADR;
                  REQ_FLUSH:   bus.state <= PKTEND_ADR;
                  default:     bus.state <= IDLE;
               endcase
            end

            // one cycle of sloe ahead of the first slrd
            DATA_TX_SLOE:
               bus.state <= DATA_TX;
            CTRL_TX_SLOE:
               bus.state <= CTRL_TX;

            // one cycle of fifoadr ahead of the first slwr
            DATA_RX_ADR:
               bus.state <= DATA_RX;
            CTRL_RX_ADR:
               bus.state <= CTRL_RX;

            PKTEND_ADR:
               bus.state <= PKTEND;
            PKTEND:
               bus.state <= IDLE;

            // transfer states run until the first cycle without a beat
            default:
            begin
               if (xfer_beat)
                  bus.xfer_count <= bus.xfer_count + 1'b1;
               else
                  bus.state <= IDLE;
            end
         endcase
      end
   end

endmodule

/* source/gpif_pin_result.sv */
//////////////////////////////////////////////////
// gpif pin result
// chip strobes and address from the bus state,
// control tx framing and the outbound word mux
//////////////////////////////////////////////////

module gpif_pin_result
   import gpif_pkg::*;
(
   gpif_bus_if.result bus,
   // head words of the two rx fifos
   input  gpif_beat_t data_rx_beat_i,
   input  gpif_beat_t ctrl_rx_beat_i,
   input  logic       ctrl_rx_src_rdy_i,
   // chip strobes, all active low
   output logic       sloe_o,
   output logic       slrd_o,
   output logic       slwr_o,
   output logic       pktend_o,
   output logic [1:0] fifoadr_o,
   output gpif_word_t gpif_d_o,
   output logic       gpif_d_oe_o,
   // control tx framing marks
   output logic       ctrl_sop_o,
   output logic       ctrl_eop_o
);

   logic tx_phase;
   logic rx_phase;
   logic flush_phase;
   logic pktend_ctrl;

   always_comb
   begin
      // chip drives the bus in the tx states
      tx_phase    = (bus.state == DATA_TX_SLOE) || (bus.state == DATA_TX)
                    || (bus.state == CTRL_TX_SLOE) || (bus.state == CTRL_TX);
      rx_phase    = (bus.state == DATA_RX_ADR) || (bus.state == DATA_RX)
                    || (bus.state == CTRL_RX_ADR) || (bus.state == CTRL_RX);
      flush_phase = (bus.state == PKTEND_ADR) || (bus.state == PKTEND);
      // close the response when the stream runs dry or its last word goes out
      pktend_ctrl = (bus.state == CTRL_RX)
                    && (!ctrl_rx_src_rdy_i || (bus.wr_beat && ctrl_rx_beat_i[17]));
   end

   // 00 ep2, 01 ep4, 10 ep6, 11 ep8
   assign fifoadr_o = {rx_phase | flush_phase, bus.wr_ep_ctrl};

   assign sloe_o   = ~tx_phase;
   // read and write are seen from the master side
   assign slrd_o   = ~bus.rd_beat;
   assign slwr_o   = ~bus.wr_beat;
   assign pktend_o = ~((bus.state == PKTEND) | pktend_ctrl);

   // outbound word follows the selected endpoint
   assign gpif_d_o    = bus.wr_ep_ctrl ? ctrl_rx_beat_i[15:0] : data_rx_beat_i[15:0];
   assign gpif_d_oe_o = rx_phase;

   // framing from the line count of the control burst
   assign ctrl_sop_o = (bus.xfer_count == '0);
   assign ctrl_eop_o = (bus.xfer_count == xfer_count_t'(GPIF_CTRL_XFER_LINES - 1));

endmodule

/* source/gpif_master_top.sv */
//////////////////////////////////////////////////
// gpif slave fifo bus master
// moves words between the four chip endpoints and
// four local streams through single clock fifos
//////////////////////////////////////////////////

module gpif_master_top
   import gpif_pkg::*;
(
   input  logic       gpif_clk,
   input  logic       gpif_rst,
   // chip pins
   input  gpif_word_t gpif_d_i,
   input  logic [3:0] gpif_ctl_i,
   output gpif_word_t gpif_d_o,
   output logic       gpif_d_oe_o,
   output logic       sloe_o,
   output logic       slrd_o,
   output logic       slwr_o,
   output logic       pktend_o,
   output logic [1:0] fifoadr_o,
   input  logic       dsp_rx_run_i,
   // host data out of ep2
   output gpif_word_t tx_data_o,
   output logic       tx_src_rdy_o,
   input  logic       tx_dst_rdy_i,
   // host control out of ep4, framed
   output gpif_beat_t ctrl_data_o,
   output logic       ctrl_src_rdy_o,
   input  logic       ctrl_dst_rdy_i,
   // data into ep6
   input  gpif_beat_t rx_data_i,
   input  logic       rx_src_rdy_i,
   output logic       rx_dst_rdy_o,
   // control response into ep8
   input  gpif_beat_t resp_data_i,
   input  logic       resp_src_rdy_i,
   output logic       resp_dst_rdy_o
);

   gpif_bus_if bus ();

   gpif_beat_t  tx_fifo_beat;
   gpif_beat_t  data_rx_beat;
   gpif_beat_t  ctrl_rx_beat;
   fifo_space_t data_tx_space;
   logic        data_tx_dst_rdy;
   logic        ctrl_tx_dst_rdy;
   logic        data_rx_src_rdy;
   logic        ctrl_rx_src_rdy;
   logic        ctrl_sop;
   logic        ctrl_eop;
   logic        data_tx_wr;
   logic        ctrl_tx_wr;
   logic        data_rx_rd;
   logic        ctrl_rx_rd;

   ////////////////////////////////////////////////
   // beat steering to the fifos
   ////////////////////////////////////////////////

   assign data_tx_wr = bus.rd_beat & ~bus.wr_ep_ctrl;
   assign ctrl_tx_wr = bus.rd_beat & bus.wr_ep_ctrl;
   assign data_rx_rd = bus.wr_beat & ~bus.wr_ep_ctrl;
   assign ctrl_rx_rd = bus.wr_beat & bus.wr_ep_ctrl;

   // data tx carries no marks
   assign tx_data_o = tx_fifo_beat[15:0];

   ////////////////////////////////////////////////
   // fifos
   ////////////////////////////////////////////////

   gpif_sync_fifo u_data_tx_fifo (
      .gpif_clk  (gpif_clk),
      .gpif_rst  (gpif_rst),
      .data_i    ({2'b00, gpif_d_i}),
      .src_rdy_i (data_tx_wr),
      .dst_rdy_o (data_tx_dst_rdy),
      .data_o    (tx_fifo_beat),
      .src_rdy_o (tx_src_rdy_o),
      .dst_rdy_i (tx_dst_rdy_i),
      .space_o   (data_tx_space)
   );

   // control tx gains its start and end marks on the way in
   gpif_sync_fifo u_ctrl_tx_fifo (
      .gpif_clk  (gpif_clk),
      .gpif_rst  (gpif_rst),
      .data_i    ({ctrl_eop, ctrl_sop, gpif_d_i}),
      .src_rdy_i (ctrl_tx_wr),
      .dst_rdy_o (ctrl_tx_dst_rdy),
      .data_o    (ctrl_data_o),
      .src_rdy_o (ctrl_src_rdy_o),
      .dst_rdy_i (ctrl_dst_rdy_i),
      .space_o   ()
   );

   gpif_sync_fifo u_data_rx_fifo (
      .gpif_clk  (gpif_clk),
      .gpif_rst  (gpif_rst),
      .data_i    (rx_data_i),
      .src_rdy_i (rx_src_rdy_i),
      .dst_rdy_o (rx_dst_rdy_o),
      .data_o    (data_rx_beat),
      .src_rdy_o (data_rx_src_rdy),
      .dst_rdy_i (data_rx_rd),
      .space_o   ()
   );

   gpif_sync_fifo u_ctrl_rx_fifo (
      .gpif_clk  (gpif_clk),
      .gpif_rst  (gpif_rst),
      .data_i    (resp_data_i),
      .src_rdy_i (resp_src_rdy_i),
      .dst_rdy_o (resp_dst_rdy_o),
      .data_o    (ctrl_rx_beat),
      .src_rdy_o (ctrl_rx_src_rdy),
      .dst_rdy_i (ctrl_rx_rd),
      .space_o   ()
   );

   ////////////////////////////////////////////////
   // decode, execute, result
   ////////////////////////////////////////////////

   gpif_flag_decode u_decode (
      .gpif_clk          (gpif_clk),
      .gpif_rst          (gpif_rst),
      .gpif_ctl_i        (gpif_ctl_i),
      .dsp_rx_run_i      (dsp_rx_run_i),
      .data_tx_space_i   (data_tx_space),
      .ctrl_tx_dst_rdy_i (ctrl_tx_dst_rdy),
      .data_rx_src_rdy_i (data_rx_src_rdy),
      .ctrl_rx_src_rdy_i (ctrl_rx_src_rdy),
      .data_rx_eof_i     (data_rx_beat[17]),
      .bus               (bus.decode)
   );

   gpif_xfer_execute u_execute (
      .gpif_clk          (gpif_clk),
      .gpif_rst          (gpif_rst),
      .data_tx_dst_rdy_i (data_tx_dst_rdy),
      .ctrl_tx_dst_rdy_i (ctrl_tx_dst_rdy),
      .data_rx_src_rdy_i (data_rx_src_rdy),
      .ctrl_rx_src_rdy_i (ctrl_rx_src_rdy),
      .bus               (bus.execute)
   );

   gpif_pin_result u_result (
      .bus               (bus.result),
      .data_rx_beat_i    (data_rx_beat),
      .ctrl_rx_beat_i    (ctrl_rx_beat),
      .ctrl_rx_src_rdy_i (ctrl_rx_src_rdy),
      .sloe_o            (sloe_o),
      .slrd_o            (slrd_o),
      .slwr_o            (slwr_o),
      .pktend_o          (pktend_o),
      .fifoadr_o         (fifoadr_o),
      .gpif_d_o          (gpif_d_o),
      .gpif_d_oe_o       (gpif_d_oe_o),
      .ctrl_sop_o        (ctrl_sop),
      .ctrl_eop_o        (ctrl_eop)
   );

endmodule

/* dv/fx2_model.sv */
//////////////////////////////////////////////////
// usb bridge chip model, slave fifo mode
// four endpoint queues with active low flags,
// host side push and device side pop tasks
//////////////////////////////////////////////////

module fx2_model
(
   input  logic        gpif_clk,
   input  logic        sloe_i,
   input  logic        slrd_i,
   input  logic        slwr_i,
   input  logic        pktend_i,
   input  logic [1:0]  fifoadr_i,
   input  logic [15:0] d_i,
   output logic [15:0] d_o,
   output logic [3:0]  ctl_o
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [15:0] ep2_q[$];
   logic [15:0] ep4_q[$];
   logic [15:0] ep6_q[$];
   logic [15:0] ep8_q[$];
   int          ep2_cnt = 0;
   int          ep4_cnt = 0;
   int          ep6_cnt = 0;
   int          ep8_cnt = 0;
   int          ep6_cap = 512;
   int          ep8_cap = 512;
   logic [15:0] ep2_head = '0;
   logic [15:0] ep4_head = '0;
   // pktend bookkeeping per endpoint address
   int          pkt_pulses [4];
   int          pkt_words [4];
   int          pkt_with_wr [4];
   logic        prev_pktend = 1'b1;
   // pin levels seen at the current edge
   logic        edge_rd;
   logic        edge_wr;
   logic        edge_pktend;
   logic [1:0]  edge_adr;
   logic [15:0] edge_word;

   // head words follow the queues
   task automatic refresh_heads();
      ep2_head = (ep2_q.size() != 0) ? ep2_q[0] : 16'h0000;
      ep4_head = (ep4_q.size() != 0) ? ep4_q[0] : 16'h0000;
      ep2_cnt  = ep2_q.size();
      ep4_cnt  = ep4_q.size();
      ep6_cnt  = ep6_q.size();
      ep8_cnt  = ep8_q.size();
   endtask

   // host side, ep 0 is ep2 and ep 1 is ep4
   task automatic host_push(input int ep, input logic [15:0] w);
      if (ep == 0)
         ep2_q.push_back(w);
      else
         ep4_q.push_back(w);
      refresh_heads();
   endtask

   // host side, ep 2 is ep6 and ep 3 is ep8
   task automatic host_pop(input int ep, output logic [15:0] w);
      w = 16'h0000;
      if (ep == 2 && ep6_q.size() != 0)
         w = ep6_q.pop_front();
      else if (ep == 3 && ep8_q.size() != 0)
         w = ep8_q.pop_front();
      refresh_heads();
   endtask

   task automatic set_capacity(input int cap);
      ep6_cap = cap;
   endtask

   task automatic clear_pktend();
      for (int i = 0; i < 4; i++)
      begin
         pkt_pulses[i]  = 0;
         pkt_words[i]   = 0;
         pkt_with_wr[i] = 0;
      end
   endtask

   // flags lead by one word so the registered copy in the master is exact
   assign ctl_o[0] = !(ep2_cnt == 0 || (ep2_cnt == 1 && !slrd_i && fifoadr_i == 2'b00));
   assign ctl_o[1] = !(ep4_cnt == 0 || (ep4_cnt == 1 && !slrd_i && fifoadr_i == 2'b01));
   assign ctl_o[2] = !(ep6_cnt >= ep6_cap
                       || (ep6_cnt == ep6_cap - 1 && !slwr_i && fifoadr_i == 2'b10));
   assign ctl_o[3] = !(ep8_cnt >= ep8_cap
                       || (ep8_cnt == ep8_cap - 1 && !slwr_i && fifoadr_i == 2'b11));

   // chip drives the bus only with sloe low
   assign d_o = sloe_i ? 16'h0000 : ((fifoadr_i == 2'b01) ? ep4_head : ep2_head);

   always @(posedge gpif_clk)
   begin
      edge_rd     = !slrd_i;
      edge_wr     = !slwr_i;
      edge_pktend = pktend_i;
      edge_adr    = fifoadr_i;
      edge_word   = d_i;
      // the chip moves its queues just after the edge that the master samples
      #0.5;
      if (edge_rd)
      begin
         if (edge_adr == 2'b00 && ep2_q.size() != 0)
            void'(ep2_q.pop_front());
         else if (edge_adr == 2'b01 && ep4_q.size() != 0)
            void'(ep4_q.pop_front());
      end
      if (edge_wr)
      begin
         // a write into a full endpoint is dropped
         if (edge_adr == 2'b10 && ep6_q.size() < ep6_cap)
            ep6_q.push_back(edge_word);
         else if (edge_adr == 2'b11 && ep8_q.size() < ep8_cap)
            ep8_q.push_back(edge_word);
      end
      refresh_heads();
      // a pulse counts once, on its first low edge
      if (!edge_pktend && prev_pktend)
      begin
         pkt_pulses[edge_adr]++;
         pkt_words[edge_adr]   = (edge_adr == 2'b11) ? ep8_cnt : ep6_cnt;
         pkt_with_wr[edge_adr] = edge_wr;
      end
      prev_pktend = edge_pktend;
   end

endmodule

/* dv/gpif_tb.sv */
//////////////////////////////////////////////////
// gpif bus master testbench
// table driven cases over the four endpoints,
// checked against the chip model queues
//////////////////////////////////////////////////

module gpif_tb
   import gpif_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_CASES = 5;
   localparam int TIMEOUT_CYCLES = 4000;

   logic        gpif_clk;
   logic        gpif_rst;
   gpif_word_t  gpif_d_i;
   logic [3:0]  gpif_ctl_i;
   gpif_word_t  gpif_d_o;
   logic        gpif_d_oe_o;
   logic        sloe_o;
   logic        slrd_o;
   logic        slwr_o;
   logic        pktend_o;
   logic [1:0]  fifoadr_o;
   logic        dsp_rx_run_i;
   gpif_word_t  tx_data_o;
   logic        tx_src_rdy_o;
   logic        tx_dst_rdy_i;
   gpif_beat_t  ctrl_data_o;
   logic        ctrl_src_rdy_o;
   logic        ctrl_dst_rdy_i;
   gpif_beat_t  rx_data_i;
   logic        rx_src_rdy_i;
   logic        rx_dst_rdy_o;
   gpif_beat_t  resp_data_i;
   logic        resp_src_rdy_i;
   logic        resp_dst_rdy_o;

   // case table, ep 0..3 maps to ep2, ep4, ep6, ep8
   int case_ep [NUM_CASES];
   int case_len [NUM_CASES];
   int case_eof [NUM_CASES];
   int case_run [NUM_CASES];
   int case_cap [NUM_CASES];
   int case_stall [NUM_CASES];

   int          seed = 29816;
   int          error_count = 0;
   logic [15:0] exp_q[$];
   // words in the data tx fifo as seen from the pins
   int          tx_level = 0;
   logic        prev_slrd = 1'b1;

   gpif_master_top uut (.*);

   fx2_model u_fx2 (
      .gpif_clk  (gpif_clk),
      .sloe_i    (sloe_o),
      .slrd_i    (slrd_o),
      .slwr_i    (slwr_o),
      .pktend_i  (pktend_o),
      .fifoadr_i (fifoadr_o),
      .d_i       (gpif_d_o),
      .d_o       (gpif_d_i),
      .ctl_o     (gpif_ctl_i)
   );

   initial
   begin
      gpif_clk = 1'b0;
      forever #4 gpif_clk = ~gpif_clk;
   end

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      if (got !== exp)
      begin
         error_count++;
         $display("error: %s got %h expected %h", name, got, exp);
         $display("Something failed");
         $fatal(1);
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timed out while waiting for %s", what);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic drive_cycle();
      @(posedge gpif_clk);
      #1;
   endtask

   ////////////////////////////////////////////////
   // pin monitor
   ////////////////////////////////////////////////

   // a data burst may only start with room for a whole burst
   always @(negedge gpif_clk)
   begin
      if (!gpif_rst)
      begin
         if (!slrd_o && fifoadr_o == 2'b00 && prev_slrd)
            check_val("tx_fifo_free_at_burst", (GPIF_FIFO_DEPTH - tx_level) >= 16, 1);
         if (!slrd_o && fifoadr_o == 2'b00)
            tx_level++;
         if (tx_src_rdy_o && tx_dst_rdy_i)
            tx_level--;
         prev_slrd = slrd_o;
         // chip drives the bus on reads, the master on writes
         if (!slwr_o)
            check_val("gpif_d_oe_o", gpif_d_oe_o, 1);
         if (!sloe_o)
            check_val("gpif_d_oe_o", gpif_d_oe_o, 0);
      end
   end

   ////////////////////////////////////////////////
   // case runners
   ////////////////////////////////////////////////

   task automatic check_reset_idle();
      for (int i = 0; i < 20; i++)
      begin
         @(negedge gpif_clk);
         check_val("sloe_o", sloe_o, 1);
         check_val("slrd_o", slrd_o, 1);
         check_val("slwr_o", slwr_o, 1);
         check_val("pktend_o", pktend_o, 1);
         check_val("fifoadr_o", fifoadr_o, 0);
         check_val("gpif_d_oe_o", gpif_d_oe_o, 0);
         check_val("tx_src_rdy_o", tx_src_rdy_o, 0);
         check_val("ctrl_src_rdy_o", ctrl_src_rdy_o, 0);
      end
   endtask

   // ep2 or ep4 words out on the tx streams
   task automatic run_host_case(input int ep, input int len, input int stall);
      int   idx;
      int   timer;
      logic rdy;
      idx   = 0;
      timer = 0;
      for (int i = 0; i < len; i++)
         u_fx2.host_push(ep, exp_q[i]);
      while (idx < len)
      begin
         drive_cycle();
         // mostly stalled so the tx fifo fills past half
         rdy = (stall == 0) || (($random(seed) & 3) == 0);
         tx_dst_rdy_i   = (ep == 0) ? rdy : 1'b0;
         ctrl_dst_rdy_i = (ep == 1) ? rdy : 1'b0;
         @(negedge gpif_clk);
         if (ep == 0 && tx_src_rdy_o && tx_dst_rdy_i)
         begin
            check_val("tx_data_o", tx_data_o, exp_q[idx]);
            idx++;
         end
         else if (ep == 1 && ctrl_src_rdy_o && ctrl_dst_rdy_i)
         begin
            check_val("ctrl_data_o", ctrl_data_o[15:0], exp_q[idx]);
            check_val("ctrl_sop", ctrl_data_o[16], idx == 0);
            check_val("ctrl_eop", ctrl_data_o[17], idx == len - 1);
            idx++;
         end
         timer++;
         if (timer > TIMEOUT_CYCLES)
            report_timeout("host words on the tx stream");
      end
      drive_cycle();
      tx_dst_rdy_i   = 1'b1;
      ctrl_dst_rdy_i = 1'b1;
      @(negedge gpif_clk);
      // nothing read twice and nothing left behind
      check_val("ep2_count", u_fx2.ep2_cnt, 0);
      check_val("ep4_count", u_fx2.ep4_cnt, 0);
      check_val("tx_src_rdy_o", tx_src_rdy_o, 0);
      check_val("ctrl_src_rdy_o", ctrl_src_rdy_o, 0);
   endtask

   task automatic drain_dev(input int ep, inout int got);
      logic [15:0] w;
      while ((ep == 2 && u_fx2.ep6_cnt != 0) || (ep == 3 && u_fx2.ep8_cnt != 0))
      begin
         u_fx2.host_pop(ep, w);
         check_val((ep == 2) ? "ep6_word" : "ep8_word", w, exp_q[got]);
         got++;
      end
   endtask

   // rx or response stream words into ep6 or ep8
   task automatic run_dev_case(input int ep, input int len, input int eof,
                               input int cap, input int stall);
      int   sent;
      int   got;
      int   timer;
      int   held;
      logic valid;
      logic [17:0] beat;
      sent  = 0;
      got   = 0;
      timer = 0;
      u_fx2.set_capacity(cap);
      u_fx2.clear_pktend();
      while (got + ((ep == 2) ? u_fx2.ep6_cnt : u_fx2.ep8_cnt) < len)
      begin
         drive_cycle();
         if ((ep == 2 && u_fx2.ep6_cnt >= cap) || (ep == 3 && u_fx2.ep8_cnt >= cap))
            drain_dev(ep, got);
         valid = (sent < len) && ((stall == 0) || (($random(seed) & 3) != 0));
         beat  = {(eof != 0) && (sent == len - 1), 1'b0, exp_q[sent % len]};
         rx_src_rdy_i   = (ep == 2) ? valid : 1'b0;
         resp_src_rdy_i = (ep == 3) ? valid : 1'b0;
         rx_data_i      = beat;
         resp_data_i    = beat;
         @(negedge gpif_clk);
         if ((ep == 2 && rx_src_rdy_i && rx_dst_rdy_o)
             || (ep == 3 && resp_src_rdy_i && resp_dst_rdy_o))
            sent++;
         timer++;
         if (timer > TIMEOUT_CYCLES)
            report_timeout("stream words in the chip endpoint");
      end
      drive_cycle();
      rx_src_rdy_i   = 1'b0;
      resp_src_rdy_i = 1'b0;
      if (eof != 0)
      begin
         timer = 0;
         while (u_fx2.pkt_pulses[ep] == 0)
         begin
            drive_cycle();
            timer++;
            if (timer > TIMEOUT_CYCLES)
               report_timeout("the pktend pulse");
         end
         check_val("pktend_words", u_fx2.pkt_words[ep], len);
         check_val("pktend_with_slwr", u_fx2.pkt_with_wr[ep], ep == 3);
      end
      // observe a while for a second pulse
      for (held = 0; held < 100; held++)
         drive_cycle();
      check_val("pktend_pulses", u_fx2.pkt_pulses[ep], eof != 0);
      check_val("pktend_other", u_fx2.pkt_pulses[5 - ep], 0);
      drain_dev(ep, got);
      check_val("words_received", got, len);
      u_fx2.set_capacity(512);
   endtask

   ////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////

   initial
   begin
      // ep2 under stalls, ep4 packet, ep6 with flush, ep8 response, ep6 tight
      case_ep = '{0, 1, 2, 3, 2};
      case_len = '{40, 16, 20, 3, 30};
      case_eof = '{0, 0, 1, 1, 0};
      case_run = '{1, 1, 0, 1, 1};
      case_cap = '{512, 512, 512, 512, 8};
      case_stall = '{1, 1, 0, 0, 1};

      gpif_rst       = 1'b1;
      dsp_rx_run_i   = 1'b1;
      tx_dst_rdy_i   = 1'b1;
      ctrl_dst_rdy_i = 1'b1;
      rx_data_i      = '0;
      rx_src_rdy_i   = 1'b0;
      resp_data_i    = '0;
      resp_src_rdy_i = 1'b0;
      u_fx2.clear_pktend();
      repeat (16) @(posedge gpif_clk);
      #1;
      gpif_rst = 1'b0;

      check_reset_idle();

      for (int c = 0; c < NUM_CASES; c++)
      begin
         exp_q.delete();
         for (int i = 0; i < case_len[c]; i++)
            exp_q.push_back(16'($random(seed)));
         drive_cycle();
         dsp_rx_run_i = case_run[c][0];
         if (case_ep[c] < 2)
            run_host_case(case_ep[c], case_len[c], case_stall[c]);
         else
            run_dev_case(case_ep[c], case_len[c], case_eof[c], case_cap[c],
                         case_stall[c]);
         dsp_rx_run_i = 1'b1;
      end

      if (error_count == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

/* gpif_master.f */
source/gpif_pkg.sv
source/gpif_bus_if.sv
source/gpif_sync_fifo.sv
source/gpif_flag_decode.sv
source/gpif_xfer_execute.sv
source/gpif_pin_result.sv
source/gpif_master_top.sv
dv/fx2_model.sv
dv/gpif_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = gpif_tb
FILELIST  = gpif_master.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Everything OK"

clean:
	rm -rf obj_dir
